//--- avs_mem_subsys.f
common/avs_pkg.sv
rtl/sync_fifo.sv
rtl/rr_rsp_arbiter.sv
avs_adapter/avs_bank_sram.sv
avs_adapter/avs_adapter.sv
rtl/avs_mem_subsys.sv
verification/avs_mem_subsys_assert.sv
verification/avs_mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run with Verilator, the verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module avs_mem_subsys_tb \
    -f avs_mem_subsys.f -o avs_mem_subsys_sim > build.log 2>&1 \
    && ./obj_dir/avs_mem_subsys_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0

//--- verification/avs_mem_subsys_tb.sv
`timescale 1ns/1ps

module avs_mem_subsys_tb;
    import avs_pkg::*;

    // about 200 transactions at up to 20 cycles each
    localparam int max_cycles = 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  mem_req_valid;
    mem_req_t              mem_req;
    logic                  mem_req_ready;
    logic                  mem_rsp_valid;
    mem_rsp_t              mem_rsp;
    logic                  mem_rsp_ready;
    logic [15:0]           lfsr = 16'd14;
    logic [data_w-1:0]     ref_mem [2**addr_w];
    mem_rsp_t              exp_q [num_banks][$];
    logic [bank_sel_w-1:0] tag_bank [2**tag_w];
    logic [tag_w-1:0]      next_tag = '0;
    int                    fail_cnt = 0;
    int                    other_cnt = 0;
    int                    cycle_cnt = 0;

    avs_mem_subsys dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            other_cnt++;
            $display("timeout after %0d cycles, value errors %0d, other errors %0d",
                     cycle_cnt, fail_cnt, other_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // galois lfsr x^16+x^14+x^13+x^11+1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [addr_w-1:0] rand_addr(input int bank);
        return {bank_addr_w'(take_bits(bank_addr_w)), bank_sel_w'(bank)};
    endfunction

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string what);
        if (got !== exp) begin
            fail_cnt++;
            $display("[FAIL] %0t: %s data %h tag %0d, expected data %h tag %0d",
                     $time, what, got.data, got.tag, exp.data, exp.tag);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_cnt++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // offers a request on a falling edge, gives up after max_wait cycles
    task automatic send_req(input mem_req_t req, input int max_wait, output logic ok);
        ok            = 1'b0;
        mem_req       = req;
        mem_req_valid = 1'b1;
        for (int i = 0; i < max_wait && !ok; i++) begin
            #1;
            ok = mem_req_ready;
            @(negedge clk);
        end
        if (ok) begin
            mem_req_valid = 1'b0;
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic get_rsp(output mem_rsp_t rsp);
        mem_rsp_ready = 1'b1;
        while (!mem_rsp_valid) begin
            @(negedge clk);
        end
        rsp = mem_rsp;
        @(negedge clk);
        mem_rsp_ready = 1'b0;
    endtask

    task automatic issue_write(input logic [addr_w-1:0] addr, input logic [byteen_w-1:0] be);
        logic [data_w-1:0] data;
        logic              ok;
        data = take_bits(data_w);
        for (int i = 0; i < byteen_w; i++) begin
            if (be[i]) begin
                ref_mem[addr][i*8 +: 8] = data[i*8 +: 8];
            end
        end
        send_req(mem_req_t'{rw: 1'b1, byteen: be, addr: addr, data: data, tag: '0}, 50, ok);
        check_bit(ok, 1'b1, "write accepted");
    endtask

    // records the expected response and builds the read request
    task automatic expect_read(input logic [addr_w-1:0] addr, output mem_req_t req);
        exp_q[addr[bank_sel_w-1:0]].push_back(mem_rsp_t'{data: ref_mem[addr], tag: next_tag});
        tag_bank[next_tag] = addr[bank_sel_w-1:0];
        req      = mem_req_t'{rw: 1'b0, byteen: '0, addr: addr, data: '0, tag: next_tag};
        next_tag = next_tag + 1'b1;
    endtask

    // one response, checked against the oldest prediction for its bank
    task automatic collect_rsp(output logic [bank_sel_w-1:0] bank);
        mem_rsp_t rsp;
        get_rsp(rsp);
        bank = tag_bank[rsp.tag];
        if (exp_q[bank].size() == 0) begin
            other_cnt++;
            $display("response with tag %0d arrived with nothing outstanding", rsp.tag);
        end else begin
            check_rsp(rsp, exp_q[bank].pop_front(), "read response");
        end
    endtask

    task automatic idle_after_reset();
        repeat (4) begin
            @(negedge clk);
            check_bit(mem_rsp_valid, 1'b0, "mem_rsp_valid without requests");
        end
        mem_req       = mem_req_t'{rw: 1'b1, byteen: '1, addr: rand_addr(0),
                                   data: take_bits(data_w), tag: '0};
        mem_req_valid = 1'b1;
        #1;
        check_bit(mem_req_ready, 1'b1, "mem_req_ready after reset");
        @(negedge clk);
        mem_req_valid = 1'b0;
        ref_mem[mem_req.addr] = mem_req.data;
    endtask

    task automatic write_read_pairs(input int n, input logic partial);
        logic [addr_w-1:0]     addr;
        mem_req_t              req;
        logic                  ok;
        logic [bank_sel_w-1:0] bank;
        for (int i = 0; i < n; i++) begin
            addr = rand_addr(i % num_banks);
            issue_write(addr, '1);
            if (partial) begin
                issue_write(addr, byteen_w'(take_bits(byteen_w)));
            end
            expect_read(addr, req);
            send_req(req, 50, ok);
            check_bit(ok, 1'b1, "read accepted");
            collect_rsp(bank);
        end
    endtask

    task automatic burst_reads(input int n, input logic alternate);
        logic [addr_w-1:0]     addr [2*rd_queue_depth];
        mem_req_t              req;
        logic                  ok;
        logic [bank_sel_w-1:0] bank;
        logic [bank_sel_w-1:0] prev;
        for (int i = 0; i < n; i++) begin
            addr[i] = rand_addr(i % num_banks);
            issue_write(addr[i], '1);
        end
        // mem_rsp_ready stays low, so responses pile up in the queues
        for (int i = 0; i < n; i++) begin
            expect_read(addr[i], req);
            send_req(req, 50, ok);
            check_bit(ok, 1'b1, "read accepted");
        end
        for (int i = 0; i < n; i++) begin
            collect_rsp(bank);
            if (alternate && i > 0) begin
                check_bit(bank != prev, 1'b1, "round-robin bank alternation");
            end
            prev = bank;
        end
    endtask

    task automatic backpressure_limit();
        logic [addr_w-1:0]     addr [6];
        mem_req_t              req;
        logic                  ok;
        logic [bank_sel_w-1:0] bank;
        int                    accepted;
        int                    offered;
        for (int i = 0; i < 6; i++) begin
            addr[i] = rand_addr(1);
            issue_write(addr[i], '1);
        end
        accepted = 0;
        offered  = 0;
        ok       = 1'b1;
        while (offered < 6 && ok) begin
            expect_read(addr[offered], req);
            offered++;
            send_req(req, 20, ok);
            accepted += int'(ok);
        end
        // the pending window plus the response parked in the output register
        check_bit(accepted == rd_queue_depth + 1, 1'b1, "reads accepted under back-pressure");
        // the last read is still offered and must be held off
        check_bit(mem_req_valid && !mem_req_ready, 1'b1,
                  "read held off by mem_req_ready with a full read window");
        fork
            if (!ok) begin
                send_req(req, 50, ok);
            end
            repeat (offered) begin
                collect_rsp(bank);
            end
        join
        check_bit(ok, 1'b1, "held read accepted after release");
    endtask

    initial begin
        rst_n         = 1'b0;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        mem_rsp_ready = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        write_read_pairs(num_banks, 1'b0);
        write_read_pairs(8, 1'b1);
        repeat (3) burst_reads(2 * rd_queue_depth, 1'b0);
        backpressure_limit();
        burst_reads(6, 1'b1);
        $display("value errors %0d, other errors %0d", fail_cnt, other_cnt);
        if (fail_cnt == 0 && other_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verification/avs_mem_subsys_assert.sv
`timescale 1ns/1ps

module avs_mem_subsys_assert (
    input logic                                       clk,
    input logic                                       rst_n,
    input logic                                       mem_rsp_valid,
    input logic                                       mem_rsp_ready,
    input avs_pkg::mem_rsp_t                          mem_rsp,
    input avs_pkg::avs_cmd_t [avs_pkg::num_banks-1:0] avs_cmd,
    input avs_pkg::avs_rsp_t [avs_pkg::num_banks-1:0] avs_rsp,
    input logic [avs_pkg::num_banks-1:0]              rd_accept,
    input logic [avs_pkg::num_banks-1:0]              rsp_pop,
    input logic [avs_pkg::num_banks-1:0]              tagq_full,
    input logic [avs_pkg::num_banks-1:0]              tagq_empty,
    input logic [avs_pkg::num_banks-1:0]              datq_full,
    input logic [avs_pkg::num_banks-1:0]              datq_empty
);
    import avs_pkg::*;

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid && $stable(mem_rsp))
        else $error("mem_rsp changed while stalled");

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        a_rd_wr: assert property (@(posedge clk) disable iff (!rst_n)
            !(avs_cmd[b].read && avs_cmd[b].write))
            else $error("bank %0d sees read and write together", b);
        // tag queue pushes on accepted reads, data queue on readdatavalid
        a_fifo_push: assert property (@(posedge clk) disable iff (!rst_n)
            !(rd_accept[b] && tagq_full[b]) && !(avs_rsp[b].readdatavalid && datq_full[b]))
            else $error("queue of bank %0d pushed while full", b);
        a_fifo_pop: assert property (@(posedge clk) disable iff (!rst_n)
            !(rsp_pop[b] && (tagq_empty[b] || datq_empty[b])))
            else $error("queue of bank %0d popped while empty", b);
    end

endmodule

bind avs_adapter avs_mem_subsys_assert adapter_assert_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_ready (mem_rsp_ready),
    .mem_rsp       (mem_rsp),
    .avs_cmd       (avs_cmd),
    .avs_rsp       (avs_rsp),
    .rd_accept     (rd_accept),
    .rsp_pop       (rsp_pop),
    .tagq_full     (tagq_full),
    .tagq_empty    (tagq_empty),
    .datq_full     (datq_full),
    .datq_empty    (datq_empty)
);

//--- rtl/avs_mem_subsys.sv
`timescale 1ns/1ps

module avs_mem_subsys (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              mem_req_valid,
    input  avs_pkg::mem_req_t mem_req,
    output logic              mem_req_ready,

    output logic              mem_rsp_valid,
    output avs_pkg::mem_rsp_t mem_rsp,
    input  logic              mem_rsp_ready
);
    import avs_pkg::*;

    avs_cmd_t [num_banks-1:0] avs_cmd;
    logic [num_banks-1:0]     avs_waitrequest;
    avs_rsp_t [num_banks-1:0] avs_rsp;

    avs_adapter adapter_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready),
        .avs_cmd         (avs_cmd),
        .avs_waitrequest (avs_waitrequest),
        .avs_rsp         (avs_rsp)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        avs_bank_sram bank_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .avs_cmd     (avs_cmd[b]),
            .waitrequest (avs_waitrequest[b]),
            .avs_rsp     (avs_rsp[b])
        );
    end

endmodule

//--- avs_adapter/avs_adapter.sv
`timescale 1ns/1ps

module avs_adapter (
    input  logic                                      clk,
    input  logic                                      rst_n,

    input  logic                                      mem_req_valid,
    input  avs_pkg::mem_req_t                         mem_req,
    output logic                                      mem_req_ready,

    output logic                                      mem_rsp_valid,
    output avs_pkg::mem_rsp_t                         mem_rsp,
    input  logic                                      mem_rsp_ready,

    output avs_pkg::avs_cmd_t [avs_pkg::num_banks-1:0] avs_cmd,
    input  logic [avs_pkg::num_banks-1:0]             avs_waitrequest,
    input  avs_pkg::avs_rsp_t [avs_pkg::num_banks-1:0] avs_rsp
);
    import avs_pkg::*;

    logic [bank_sel_w-1:0]                  bank_sel;
    logic [bank_addr_w-1:0]                 bank_addr;
    logic [num_banks-1:0]                   bank_hit;
    logic [num_banks-1:0]                   cmd_en;
    logic [num_banks-1:0]                   rd_accept;
    logic [num_banks-1:0][pend_cnt_w-1:0]   pending;

    logic [num_banks-1:0][tag_w-1:0]        tagq_out;
    logic [num_banks-1:0]                   tagq_empty;
    logic [num_banks-1:0]                   tagq_full;
    logic [num_banks-1:0][data_w-1:0]       datq_out;
    logic [num_banks-1:0]                   datq_empty;
    logic [num_banks-1:0]                   datq_full;

    logic [num_banks-1:0]                   arb_valid;
    mem_rsp_t [num_banks-1:0]               arb_rsp;
    logic [num_banks-1:0]                   rsp_pop;

    // low address bits pick the bank, the rest is the word inside it
    assign bank_sel  = mem_req.addr[bank_sel_w-1:0];
    assign bank_addr = mem_req.addr[addr_w-1:bank_sel_w];

    // only the selected bank can have cmd_en set
    assign mem_req_ready = |(cmd_en & ~avs_waitrequest);

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        assign bank_hit[b] = (bank_sel == bank_sel_w'(b));

        // writes are held back too while the bank has a full read window
        assign cmd_en[b] = mem_req_valid && bank_hit[b]
                         && (pending[b] < pend_cnt_w'(rd_queue_depth));

        assign avs_cmd[b] = '{
            read:       cmd_en[b] && !mem_req.rw,
            write:      cmd_en[b] && mem_req.rw,
            address:    bank_addr,
            byteenable: mem_req.byteen,
            writedata:  mem_req.data
        };

        assign rd_accept[b] = avs_cmd[b].read && !avs_waitrequest[b];

        // reads in flight or parked in the data queue
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                pending[b] <= '0;
            end else if (rd_accept[b] && !rsp_pop[b]) begin
                pending[b] <= pending[b] + 1'b1;
            end else if (rsp_pop[b] && !rd_accept[b]) begin
                pending[b] <= pending[b] - 1'b1;
            end
        end

        sync_fifo #(
            .data_w_p (tag_w),
            .depth_p  (rd_queue_depth)
        ) tag_queue_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (rd_accept[b]),
            .pop      (rsp_pop[b]),
            .data_in  (mem_req.tag),
            .data_out (tagq_out[b]),
            .empty    (tagq_empty[b]),
            .full     (tagq_full[b])
        );

        sync_fifo #(
            .data_w_p (data_w),
            .depth_p  (rd_queue_depth)
        ) data_queue_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .push     (avs_rsp[b].readdatavalid),
            .pop      (rsp_pop[b]),
            .data_in  (avs_rsp[b].readdata),
            .data_out (datq_out[b]),
            .empty    (datq_empty[b]),
            .full     (datq_full[b])
        );

        // tag head always matches data head since the bank keeps read order
        assign arb_valid[b] = !datq_empty[b];
        assign arb_rsp[b]   = '{data: datq_out[b], tag: tagq_out[b]};
    end

    rr_rsp_arbiter rsp_arb_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (arb_valid),
        .in_rsp    (arb_rsp),
        .in_grant  (rsp_pop),
        .out_valid (mem_rsp_valid),
        .out_rsp   (mem_rsp),
        .out_ready (mem_rsp_ready)
    );

endmodule

//--- avs_adapter/avs_bank_sram.sv
`timescale 1ns/1ps

module avs_bank_sram (
    input  logic              clk,
    input  logic              rst_n,
    input  avs_pkg::avs_cmd_t avs_cmd,
    output logic              waitrequest,
    output avs_pkg::avs_rsp_t avs_rsp
);
    import avs_pkg::*;

    logic [data_w-1:0]       mem [bank_words];
    logic                    busy;
    logic                    rd_accept;
    logic                    wr_accept;
    logic [read_latency-1:0] pipe_vld;
    logic [data_w-1:0]       pipe_data [read_latency];

    assign waitrequest = busy;
    assign rd_accept   = avs_cmd.read && !busy;
    assign wr_accept   = avs_cmd.write && !busy;

    // one dead cycle after every accepted command
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= rd_accept || wr_accept;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            for (int i = 0; i < byteen_w; i++) begin
                if (avs_cmd.byteenable[i]) begin
                    mem[avs_cmd.address][i*8 +: 8] <= avs_cmd.writedata[i*8 +: 8];
                end
            end
        end
    end

    // latency pipeline, stage 0 samples the array
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pipe_vld <= '0;
        end else begin
            pipe_vld[0] <= rd_accept;
            for (int i = 1; i < read_latency; i++) begin
                pipe_vld[i] <= pipe_vld[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            pipe_data[0] <= mem[avs_cmd.address];
        end
        for (int i = 1; i < read_latency; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    assign avs_rsp = '{
        readdata:      pipe_data[read_latency-1],
        readdatavalid: pipe_vld[read_latency-1]
    };

endmodule

//--- rtl/rr_rsp_arbiter.sv
`timescale 1ns/1ps

module rr_rsp_arbiter (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [avs_pkg::num_banks-1:0]            in_valid,
    input  avs_pkg::mem_rsp_t [avs_pkg::num_banks-1:0] in_rsp,
    output logic [avs_pkg::num_banks-1:0]            in_grant,
    output logic                                     out_valid,
    output avs_pkg::mem_rsp_t                        out_rsp,
    input  logic                                     out_ready
);
    import avs_pkg::*;

    logic [bank_sel_w-1:0] prio_ptr;
    logic [bank_sel_w-1:0] winner;
    logic [bank_sel_w-1:0] winner_next;
    logic                  found;
    logic                  can_load;

    // output register is free or drains at this edge
    assign can_load = !out_valid || out_ready;

    // first requester at or after the priority pointer
    always_comb begin
        int idx;
        found  = 1'b0;
        winner = '0;
        for (int i = 0; i < num_banks; i++) begin
            idx = (int'(prio_ptr) + i) % num_banks;
            if (!found && in_valid[idx]) begin
                found  = 1'b1;
                winner = bank_sel_w'(idx);
            end
        end
    end

    assign winner_next = bank_sel_w'((int'(winner) + 1) % num_banks);

    always_comb begin
        in_grant = '0;
        if (can_load && found) begin
            in_grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            prio_ptr  <= '0;
        end else if (can_load) begin
            out_valid <= found;
            if (found) begin
                prio_ptr <= winner_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && found) begin
            out_rsp <= in_rsp[winner];
        end
    end

endmodule

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int data_w_p = 8,
    parameter int depth_p  = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic                pop,
    input  logic [data_w_p-1:0] data_in,
    output logic [data_w_p-1:0] data_out,
    output logic                empty,
    output logic                full
);

    localparam int ptr_w = (depth_p > 1) ? $clog2(depth_p) : 1;
    localparam int cnt_w = $clog2(depth_p + 1);

    logic [data_w_p-1:0] storage [depth_p];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;

    // wrap explicitly so depths that are not a power of two work too
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth_p - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign data_out = storage[rd_ptr];
    assign empty    = (count == '0);
    assign full     = (count == cnt_w'(depth_p));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= data_in;
        end
    end

endmodule

//--- common/avs_pkg.sv
package avs_pkg;

    // bank organisation
    localparam int num_banks      = 2;
    localparam int bank_sel_w     = 1;

    localparam int addr_w         = 12;
    localparam int data_w         = 32;
    localparam int byteen_w       = data_w / 8;
    localparam int tag_w          = 4;

    // outstanding reads per bank, also the queue depth
    localparam int rd_queue_depth = 4;
    localparam int read_latency   = 2;

    // address inside one bank once the select bits are stripped
    localparam int bank_addr_w    = addr_w - bank_sel_w;
    localparam int bank_words     = 2 ** bank_addr_w;

    localparam int pend_cnt_w     = $clog2(rd_queue_depth + 1);

    // client request, rw high means write
    typedef struct packed {
        logic                rw;
        logic [byteen_w-1:0] byteen;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   data;
        logic [tag_w-1:0]    tag;
    } mem_req_t;

    // client read response
    typedef struct packed {
        logic [data_w-1:0] data;
        logic [tag_w-1:0]  tag;
    } mem_rsp_t;

    // adapter to bank, burstcount is fixed at one and not carried
    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [bank_addr_w-1:0] address;
        logic [byteen_w-1:0]    byteenable;
        logic [data_w-1:0]      writedata;
    } avs_cmd_t;

    // bank to adapter
    typedef struct packed {
        logic [data_w-1:0] readdata;
        logic              readdatavalid;
    } avs_rsp_t;

endpackage
